/* btb_pkg.sv */
package btb_pkg;

  // ====================================================================
  // fetch group geometry
  // ====================================================================

  localparam int FETCH_SLOTS   = 4;     // instruction slots per fetch group
  localparam int INSN_BYTES    = 5;     // fixed 40 bit instruction word
  localparam int BTB_INDEX_LSB = 12;    // bank index sits above the page offset
  localparam int BTB_DEPTH_DEF = 1024;  // entries per bank unless the top overrides

  // ====================================================================
  // address and entry types
  // ====================================================================

  typedef logic [31:0] pc_addr_t;  // byte fetch address

  // one entry per slot per bank
  // the full slot address is kept so the compare needs no separate tag
  typedef struct packed {
    logic     takb;  // set when the slot branch was taken at commit
    pc_addr_t pc;    // slot address that produced the entry
    pc_addr_t tgt;   // where the taken branch went
  } btb_entry_t;     // 65 bits in all

  // a group of FETCH_SLOTS slots spans this many bytes
  localparam int GROUP_BYTES = INSN_BYTES * FETCH_SLOTS;

endpackage

/* btb_bank.sv */
`timescale 1ns/1ps

// simple dual port entry ram
// one write port fed by the commit side, one registered read port for fetch
module btb_bank import btb_pkg::*; #(
  parameter  int DEPTH = BTB_DEPTH_DEF,
  localparam int AW    = $clog2(DEPTH)   // index width
) (
  input  logic          clk,
  input  logic          we,      // commit write strobe
  input  logic [AW-1:0] waddr,   // commit index
  input  btb_entry_t    wdata,   // entry for this bank's slot
  input  logic [AW-1:0] raddr,   // fetch index, already registered upstream
  output btb_entry_t    rdata    // valid one edge after raddr
);

  btb_entry_t mem [DEPTH];  // plain inferred ram, no vendor macro

  // start with every entry cleared
  // takb is zero so no slot can hit before a taken commit lands
  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;  // whole entry rewritten
    end
    rdata <= mem[raddr];    // same index same cycle returns the old entry
  end

endmodule

/* btb_update.sv */
`timescale 1ns/1ps

// commit side of the btb
// samples the four committed slots and turns them into bank writes
module btb_update import btb_pkg::*; #(
  parameter  int DEPTH = BTB_DEPTH_DEF,
  localparam int AW    = $clog2(DEPTH)
) (
  input  logic          clk,
  input  logic          rst,
  // committed group, slot 0 is the group base
  input  pc_addr_t      commit_pc0,
  input  pc_addr_t      commit_pc1,
  input  pc_addr_t      commit_pc2,
  input  pc_addr_t      commit_pc3,
  input  pc_addr_t      commit_tgt0,
  input  pc_addr_t      commit_tgt1,
  input  pc_addr_t      commit_tgt2,
  input  pc_addr_t      commit_tgt3,
  input  logic          commit_takb0,
  input  logic          commit_takb1,
  input  logic          commit_takb2,
  input  logic          commit_takb3,
  // write side of all four banks
  output logic          we,
  output logic [AW-1:0] waddr,
  output btb_entry_t    wdata0,
  output btb_entry_t    wdata1,
  output btb_entry_t    wdata2,
  output btb_entry_t    wdata3
);

  // ====================================================================
  // commit register stage
  // ====================================================================

  always_ff @(posedge clk) begin
    if (rst) begin
      we     <= 1'b0;
      waddr  <= '0;
      wdata0 <= '0;
      wdata1 <= '0;
      wdata2 <= '0;
      wdata3 <= '0;
    end else begin
      // every slot is captured, taken or not
      wdata0 <= '{takb: commit_takb0, pc: commit_pc0, tgt: commit_tgt0};
      wdata1 <= '{takb: commit_takb1, pc: commit_pc1, tgt: commit_tgt1};
      wdata2 <= '{takb: commit_takb2, pc: commit_pc2, tgt: commit_tgt2};
      wdata3 <= '{takb: commit_takb3, pc: commit_pc3, tgt: commit_tgt3};
      waddr  <= commit_pc0[BTB_INDEX_LSB +: AW];  // whole group shares slot 0 index
      // a group with no taken branch leaves the stored entries alone
      we     <= commit_takb0 | commit_takb1 | commit_takb2 | commit_takb3;
    end
  end

endmodule

/* btb_lookup.sv */
`timescale 1ns/1ps

// fetch side of the btb
// drives the shared read index and resolves the per slot hits
module btb_lookup import btb_pkg::*; #(
  parameter  int DEPTH = BTB_DEPTH_DEF,
  localparam int AW    = $clog2(DEPTH)
) (
  input  logic          clk,
  input  logic          en,       // hit enable
  input  pc_addr_t      pc0,      // slot addresses of the current group
  input  pc_addr_t      pc1,
  input  pc_addr_t      pc2,
  input  pc_addr_t      pc3,
  output logic [AW-1:0] raddr,    // shared read index into the four banks
  input  btb_entry_t    rdata0,   // one entry per bank
  input  btb_entry_t    rdata1,
  input  btb_entry_t    rdata2,
  input  btb_entry_t    rdata3,
  output logic          hit,      // some slot hit
  output pc_addr_t      hit_tgt   // target of the lowest hitting slot
);

  pc_addr_t               slot_pc  [FETCH_SLOTS];  // slot k address
  btb_entry_t             slot_ent [FETCH_SLOTS];  // bank k entry
  logic [FETCH_SLOTS-1:0] slot_hit;                // per slot hit

  assign slot_pc[0]  = pc0;
  assign slot_pc[1]  = pc1;
  assign slot_pc[2]  = pc2;
  assign slot_pc[3]  = pc3;
  assign slot_ent[0] = rdata0;
  assign slot_ent[1] = rdata1;
  assign slot_ent[2] = rdata2;
  assign slot_ent[3] = rdata3;

  // ====================================================================
  // index register
  // ====================================================================

  // first edge after pc0 moves, the bank read lands on the next one
  always_ff @(posedge clk) begin
    raddr <= pc0[BTB_INDEX_LSB +: AW];
  end

  // ====================================================================
  // hit resolve
  // ====================================================================

  always_comb begin
    for (int k = 0; k < FETCH_SLOTS; k++) begin
      slot_hit[k] = en && slot_ent[k].takb     // only taken entries redirect
                    && (slot_pc[k] == slot_ent[k].pc);  // full address compare
    end
  end

  // walk down so the lowest slot ends up winning
  always_comb begin
    hit     = |slot_hit;
    hit_tgt = '0;
    for (int k = FETCH_SLOTS - 1; k >= 0; k--) begin
      if (slot_hit[k]) begin
        hit_tgt = slot_ent[k].tgt;
      end
    end
  end

endmodule

/* next_pc_select.sv */
`timescale 1ns/1ps

// next fetch address priority
// miss redirect, then subroutine target, then btb hit, then sequential
module next_pc_select import btb_pkg::*; (
  input  pc_addr_t pc,                 // current group address
  input  logic     miss_done,          // branch miss recovery finished
  input  pc_addr_t misspc,             // restart address after a miss
  input  logic     do_bsr,             // subroutine call redirect
  input  pc_addr_t bsr_tgt,
  input  logic     hit,                // btb hit from lookup
  input  pc_addr_t hit_tgt,
  input  logic     micro_code_active,  // microcode owns the fetch
  input  logic     mip0v,              // valid markers per slot
  input  logic     mip1v,
  input  logic     mip2v,
  input  logic     mip3v,
  output pc_addr_t next_pc,
  output logic     takb                // next_pc is a redirect
);

  logic [FETCH_SLOTS-1:0] mip;       // markers gathered low slot first
  pc_addr_t               seq_step;  // byte step for the sequential case
  pc_addr_t               seq_pc;    // sequential next address

  assign mip = {mip3v, mip2v, mip1v, mip0v};

  // ====================================================================
  // sequential step
  // ====================================================================

  // lowest set marker k steps k+1 instructions, no marker steps a whole group
  always_comb begin
    seq_step = pc_addr_t'(GROUP_BYTES);
    for (int k = FETCH_SLOTS - 1; k >= 0; k--) begin
      if (mip[k]) begin
        seq_step = pc_addr_t'(INSN_BYTES * (k + 1));
      end
    end
  end

  assign seq_pc = micro_code_active ? pc            // hold while microcode runs
                                    : pc + seq_step;

  // ====================================================================
  // redirect priority
  // ====================================================================

  always_comb begin
    if (miss_done) begin
      next_pc = misspc;    // miss recovery beats everything
      takb    = 1'b1;
    end else if (do_bsr) begin
      next_pc = bsr_tgt;
      takb    = 1'b1;
    end else if (hit) begin
      next_pc = hit_tgt;   // predicted taken
      takb    = 1'b1;
    end else begin
      next_pc = seq_pc;
      takb    = 1'b0;
    end
  end

endmodule

/* btb_top.sv */
`timescale 1ns/1ps

// branch target buffer with next fetch address select
// four banks share one read index, one per slot of the fetch group
module btb_top import btb_pkg::*; #(
  parameter int DEPTH = BTB_DEPTH_DEF
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     en,
  // fetch group
  input  pc_addr_t pc,
  input  pc_addr_t pc0,
  input  pc_addr_t pc1,
  input  pc_addr_t pc2,
  input  pc_addr_t pc3,
  input  logic     mip0v,
  input  logic     mip1v,
  input  logic     mip2v,
  input  logic     mip3v,
  input  logic     micro_code_active,
  // redirects
  input  logic     miss_done,
  input  pc_addr_t misspc,
  input  logic     do_bsr,
  input  pc_addr_t bsr_tgt,
  // commit group
  input  pc_addr_t commit_pc0,
  input  pc_addr_t commit_pc1,
  input  pc_addr_t commit_pc2,
  input  pc_addr_t commit_pc3,
  input  pc_addr_t commit_tgt0,
  input  pc_addr_t commit_tgt1,
  input  pc_addr_t commit_tgt2,
  input  pc_addr_t commit_tgt3,
  input  logic     commit_takb0,
  input  logic     commit_takb1,
  input  logic     commit_takb2,
  input  logic     commit_takb3,
  // next fetch
  output pc_addr_t next_pc,
  output logic     takb
);

  localparam int AW = $clog2(DEPTH);

  logic          we;       // bank write strobe
  logic [AW-1:0] waddr;
  btb_entry_t    wdata0, wdata1, wdata2, wdata3;
  logic [AW-1:0] raddr;    // shared read index
  btb_entry_t    rdata0, rdata1, rdata2, rdata3;
  logic          hit;
  pc_addr_t      hit_tgt;

  // ====================================================================
  // entry store
  // ====================================================================

  btb_bank #(.DEPTH(DEPTH)) bank0_i (
    .clk, .we, .waddr, .wdata(wdata0), .raddr, .rdata(rdata0)
  );

  btb_bank #(.DEPTH(DEPTH)) bank1_i (
    .clk, .we, .waddr, .wdata(wdata1), .raddr, .rdata(rdata1)
  );

  btb_bank #(.DEPTH(DEPTH)) bank2_i (
    .clk, .we, .waddr, .wdata(wdata2), .raddr, .rdata(rdata2)
  );

  btb_bank #(.DEPTH(DEPTH)) bank3_i (
    .clk, .we, .waddr, .wdata(wdata3), .raddr, .rdata(rdata3)
  );

  // ====================================================================
  // commit and fetch paths
  // ====================================================================

  btb_update #(.DEPTH(DEPTH)) update_i (
    .clk, .rst,
    .commit_pc0, .commit_pc1, .commit_pc2, .commit_pc3,
    .commit_tgt0, .commit_tgt1, .commit_tgt2, .commit_tgt3,
    .commit_takb0, .commit_takb1, .commit_takb2, .commit_takb3,
    .we, .waddr,
    .wdata0, .wdata1, .wdata2, .wdata3
  );

  btb_lookup #(.DEPTH(DEPTH)) lookup_i (
    .clk, .en,
    .pc0, .pc1, .pc2, .pc3,
    .raddr,
    .rdata0, .rdata1, .rdata2, .rdata3,
    .hit, .hit_tgt
  );

  // purely combinational from here to next_pc and takb
  next_pc_select select_i (
    .pc,
    .miss_done, .misspc,
    .do_bsr, .bsr_tgt,
    .hit, .hit_tgt,
    .micro_code_active,
    .mip0v, .mip1v, .mip2v, .mip3v,
    .next_pc, .takb
  );

endmodule

/* btb_checker.sv */
`timescale 1ns/1ps

// concurrent properties on the btb top level
module btb_checker import btb_pkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     we,                 // internal bank write strobe
  input pc_addr_t pc,
  input logic     miss_done,
  input pc_addr_t misspc,
  input logic     do_bsr,
  input logic     hit,                // internal lookup hit
  input logic     micro_code_active,
  input pc_addr_t next_pc,
  input logic     takb
);

  int fail_count = 0;  // read by the testbench at the end

  // ====================================================================
  // properties
  // ====================================================================

  // miss recovery always redirects to misspc
  assert property (@(posedge clk) disable iff (rst)
    miss_done |-> (takb && next_pc == misspc))
  else begin
    fail_count++;
    $error("miss_done without redirect to misspc");
  end

  assert property (@(posedge clk) disable iff (rst)
    (!miss_done && !do_bsr && !hit && micro_code_active) |-> (next_pc == pc))
  else begin
    fail_count++;
    $error("next_pc moved while microcode active");
  end

  assert property (@(posedge clk) rst |=> !we)  // reset clears the write strobe
  else begin
    fail_count++;
    $error("bank write strobe high after reset");
  end

endmodule

bind btb_top btb_checker checker_i (
  .clk, .rst, .we, .pc, .miss_done, .misspc, .do_bsr, .hit,
  .micro_code_active, .next_pc, .takb
);

/* btb_tb.sv */
`timescale 1ns/1ps

// directed testbench for btb_top
// inputs move 2 ns after the rising edge, outputs are sampled a few ns later
module btb_tb import btb_pkg::*; ();

  localparam int CLK_HALF       = 20;    // 40 ns period
  localparam int DRIVE_DELAY    = 2;
  localparam int SETTLE_DELAY   = 5;     // combinational outputs stable by then
  localparam int TIMEOUT_CYCLES = 3000;  // tests need well under 200 cycles

  localparam pc_addr_t GRP_A = 32'h0040_3000;  // bank index 3
  localparam pc_addr_t TGT_S1 = 32'h0000_8100, TGT_S2 = 32'h0000_8200;
  localparam pc_addr_t TGT_S3 = 32'h0000_8300, TGT_NEW = 32'h0000_9300;
  localparam pc_addr_t BSR_TGT = 32'h0001_0000, MISS_PC = 32'h0002_0000;

  logic     clk, rst, en;
  pc_addr_t pc, pc0, pc1, pc2, pc3;
  logic     mip0v, mip1v, mip2v, mip3v, micro_code_active;
  logic     miss_done, do_bsr;
  pc_addr_t misspc, bsr_tgt;
  pc_addr_t commit_pc0, commit_pc1, commit_pc2, commit_pc3;
  pc_addr_t commit_tgt0, commit_tgt1, commit_tgt2, commit_tgt3;
  logic     commit_takb0, commit_takb1, commit_takb2, commit_takb3;
  pc_addr_t next_pc;
  logic     takb;
  int       cycles;

  btb_top btb_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $fatal(1, "timeout");
    end
  end

  // ====================================================================
  // drive helpers
  // ====================================================================

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic settle();
    #SETTLE_DELAY;
  endtask

  task automatic set_group(input pc_addr_t base);
    pc  = base;         // group address is slot 0
    pc0 = base;
    pc1 = base + 5;
    pc2 = base + 10;
    pc3 = base + 15;
  endtask

  task automatic set_mip(input logic [3:0] m);
    mip0v = m[0];
    mip1v = m[1];
    mip2v = m[2];
    mip3v = m[3];
  endtask

  task automatic drive_idle();
    en = 1'b1;
    set_group('0);
    set_mip(4'b0000);
    micro_code_active = 1'b0;
    miss_done = 1'b0;
    misspc    = '0;
    do_bsr    = 1'b0;
    bsr_tgt   = '0;
    {commit_pc0, commit_pc1, commit_pc2, commit_pc3} = '0;
    {commit_tgt0, commit_tgt1, commit_tgt2, commit_tgt3} = '0;
    {commit_takb3, commit_takb2, commit_takb1, commit_takb0} = 4'b0000;
  endtask

  // one commit cycle, then wait out the write and the bank read
  task automatic commit_group(input pc_addr_t base, input pc_addr_t t0, input pc_addr_t t1,
                              input pc_addr_t t2, input pc_addr_t t3, input logic [3:0] tk);
    commit_pc0  = base;
    commit_pc1  = base + 5;
    commit_pc2  = base + 10;
    commit_pc3  = base + 15;
    commit_tgt0 = t0;
    commit_tgt1 = t1;
    commit_tgt2 = t2;
    commit_tgt3 = t3;
    {commit_takb3, commit_takb2, commit_takb1, commit_takb0} = tk;
    wait_cycles(1);
    {commit_takb3, commit_takb2, commit_takb1, commit_takb0} = 4'b0000;
    wait_cycles(3);  // four edges from the commit in all
    settle();
  endtask

  // ====================================================================
  // expected values and compares
  // ====================================================================

  // lowest set marker k gives k+1 instructions, none gives a full group
  function automatic pc_addr_t expect_seq(input pc_addr_t cur, input logic [3:0] m,
                                          input logic mca);
    if (mca) return cur;
    for (int k = 0; k < 4; k++) begin
      if (m[k]) return cur + pc_addr_t'(5 * (k + 1));
    end
    return cur + 32'd20;
  endfunction

  task automatic check_pc(input pc_addr_t got, input pc_addr_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s next_pc %h expected %h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "next_pc compare");
    end
  endtask

  task automatic check_takb(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s takb %b expected %b", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "takb compare");
    end
  endtask

  // ====================================================================
  // directed tests
  // ====================================================================

  task automatic test_no_commit();
    set_group(GRP_A);
    wait_cycles(2);  // index register, then bank read
    for (int k = 0; k < 4; k++) begin
      set_mip(4'(1 << k));
      settle();
      check_pc(next_pc, GRP_A + pc_addr_t'(5 * (k + 1)), "single mip");
      check_takb(takb, 1'b0, "single mip");
      wait_cycles(1);
    end
    set_mip(4'b0000);
    settle();
    check_pc(next_pc, GRP_A + 32'd20, "no mip");
    check_takb(takb, 1'b0, "no mip");
    wait_cycles(1);
    micro_code_active = 1'b1;
    settle();
    check_pc(next_pc, GRP_A, "microcode hold");
    check_takb(takb, 1'b0, "microcode hold");
    wait_cycles(1);
    micro_code_active = 1'b0;
  endtask

  task automatic test_commit_hit();
    commit_group(GRP_A, '0, '0, TGT_S2, '0, 4'b0100);   // slot 2 taken
    check_pc(next_pc, TGT_S2, "slot 2 hit");
    check_takb(takb, 1'b1, "slot 2 hit");
    wait_cycles(1);
    commit_group(GRP_A, '0, TGT_S1, '0, TGT_S3, 4'b1010);  // slots 1 and 3
    check_pc(next_pc, TGT_S1, "lowest slot wins");
    check_takb(takb, 1'b1, "lowest slot wins");
    wait_cycles(1);
  endtask

  task automatic test_rewrite_and_enable();
    commit_group(GRP_A, '0, TGT_NEW, '0, TGT_NEW, 4'b0000);  // nothing taken, no write
    check_pc(next_pc, TGT_S1, "untaken commit keeps entry");
    check_takb(takb, 1'b1, "untaken commit keeps entry");
    wait_cycles(1);
    commit_group(GRP_A, '0, '0, '0, TGT_NEW, 4'b1000);  // slot 1 now not taken
    check_pc(next_pc, TGT_NEW, "rewrite drops slot 1");
    check_takb(takb, 1'b1, "rewrite drops slot 1");
    wait_cycles(1);
    en = 1'b0;
    settle();
    check_pc(next_pc, GRP_A + 32'd20, "hit gated by en");
    check_takb(takb, 1'b0, "hit gated by en");
    wait_cycles(1);
    en = 1'b1;
  endtask

  task automatic test_priority();
    do_bsr  = 1'b1;
    bsr_tgt = BSR_TGT;
    settle();
    check_pc(next_pc, BSR_TGT, "bsr over hit");
    check_takb(takb, 1'b1, "bsr over hit");
    wait_cycles(1);
    miss_done = 1'b1;
    misspc    = MISS_PC;
    settle();
    check_pc(next_pc, MISS_PC, "miss over bsr");
    check_takb(takb, 1'b1, "miss over bsr");
    wait_cycles(1);
    {miss_done, do_bsr} = 2'b00;
    settle();
    check_pc(next_pc, TGT_NEW, "hit after redirects");
    check_takb(takb, 1'b1, "hit after redirects");
    wait_cycles(1);
  endtask

  task automatic test_random_seq();
    pc_addr_t   base;
    logic [3:0] m;
    for (int i = 0; i < 50; i++) begin
      base = $urandom | 32'h0020_0000;  // index above 511, bank entries stay empty
      m    = 4'($urandom);
      set_group(base);
      set_mip(m);
      micro_code_active = ($urandom_range(0, 3) == 0);
      settle();
      check_pc(next_pc, expect_seq(base, m, micro_code_active), "random sequential");
      check_takb(takb, 1'b0, "random sequential");
      wait_cycles(1);
    end
    micro_code_active = 1'b0;
  endtask

  initial begin
    void'($urandom(22));
    cycles = 0;
    rst    = 1'b1;
    drive_idle();
    commit_takb0 = 1'b1;  // taken commit during reset must not reach the banks
    repeat (10) @(posedge clk);
    #DRIVE_DELAY;
    rst          = 1'b0;
    commit_takb0 = 1'b0;
    test_no_commit();
    test_commit_hit();
    test_rewrite_and_enable();
    test_priority();
    test_random_seq();
    wait_cycles(2);  // let the last assertion samples land
    if (btb_top_i.checker_i.fail_count != 0) begin
      $display("%0d assertion failures", btb_top_i.checker_i.fail_count);
      $display("** FAIL **");
      $fatal(1, "assertion failures");
    end else begin
      $display("** PASS **");
      $finish;
    end
  end

endmodule

/* all.f */
btb_pkg.sv
btb_bank.sv
btb_update.sv
btb_lookup.sv
next_pc_select.sv
btb_top.sv
btb_checker.sv
btb_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= btb_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ** PASS **
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list the targets"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q -F '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
